// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_panel_monitor
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := All tests passed!

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== common/panel_pkg.sv ====
`default_nettype none

package panel_pkg;

    localparam int NUM_DIGITS = 8;

    typedef logic [9:0] knob_t;   // one pot reading
    typedef logic [2:0] route_t;  // patch source index

    // all panel controls, as delivered by the pcb scanner
    typedef struct packed {
        knob_t  volume;
        knob_t  pitch;
        knob_t  delay_wet;
        knob_t  delay_rate;
        knob_t  delay_feedback;
        knob_t  reverb_wet;
        knob_t  reverb_size;
        knob_t  reverb_feedback;
        knob_t  filter_quality;
        knob_t  filter_cutoff;
        knob_t  distortion_drive;
        knob_t  crush_pressure;
        route_t output_src;
        route_t crush_src;
        route_t distortion_src;
        route_t filter_src;
        route_t reverb_src;
        route_t delay_src;
    } panel_settings_t;

    typedef enum logic [2:0] {
        PAGE_REQ_COUNT      = 3'd0,
        PAGE_VOL_PITCH      = 3'd1,
        PAGE_DLY_WET_RATE   = 3'd2,
        PAGE_DLY_FB_REV_WET = 3'd3,
        PAGE_REV_SIZE_FB    = 3'd4,
        PAGE_FILTER         = 3'd5,
        PAGE_DRIVE_CRUSH    = 3'd6,
        PAGE_ROUTES         = 3'd7
    } page_t;

    // two knobs, each right aligned in a 16 bit half
    typedef struct packed {
        logic [5:0] pad_hi;
        knob_t      knob_hi;
        logic [5:0] pad_lo;
        knob_t      knob_lo;
    } knob_pair_t;

    typedef struct packed {
        logic   zero;
        route_t src;
    } route_field_t;  // one hex digit per route

    typedef struct packed {
        logic [7:0]   pad;
        route_field_t delay;
        route_field_t reverb;
        route_field_t filter;
        route_field_t distortion;
        route_field_t crush;
        route_field_t output_jack;  // dry path
    } route_set_t;

    // display word, nibble i goes to digit i
    typedef union packed {
        knob_pair_t                 knobs;
        route_set_t                 routes;
        logic [NUM_DIGITS-1:0][3:0] nibbles;
    } disp_word_u;

    typedef logic [6:0]            seg_t;    // gfedcba, active low
    typedef logic [NUM_DIGITS-1:0] anode_t;  // active low

    localparam seg_t   SEG_BLANK = 7'h7f;
    localparam anode_t ANODE_OFF = '1;

    localparam seg_t SEG_HEX [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30,  // 0 1 2 3
        7'h19, 7'h12, 7'h02, 7'h78,  // 4 5 6 7
        7'h00, 7'h10, 7'h08, 7'h03,  // 8 9 A b
        7'h46, 7'h21, 7'h06, 7'h0e   // C d E F
    };

endpackage

`default_nettype wire

// ==== compile.f ====
common/panel_pkg.sv
hdl/knob_sync.sv
hdl/status_page_select.sv
display/seg_decoder.sv
display/digit_scan.sv
hdl/panel_monitor_top.sv
verif/tb_panel_monitor.sv

// ==== display/digit_scan.sv ====
`timescale 1ns/1ps
`default_nettype none

module digit_scan #(
    parameter int SCAN_DIV_BITS = 16
) (
    input  logic              clk_dram_ctrl,
    input  logic              rst,
    input  panel_pkg::seg_t   i_segs [panel_pkg::NUM_DIGITS],
    output panel_pkg::seg_t   o_cathode,
    output panel_pkg::anode_t o_anode
);

    localparam int IDX_W = $clog2(panel_pkg::NUM_DIGITS);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(panel_pkg::NUM_DIGITS - 1);

    logic [SCAN_DIV_BITS-1:0] scan_cnt;
    logic                     scan_wrap;
    logic [IDX_W-1:0]         digit_idx;  // digit currently lit
    logic [IDX_W-1:0]         idx_next;
    logic                     lit;        // set by the first wrap
    logic                     lit_next;

    assign scan_wrap = &scan_cnt;
    assign lit_next  = lit | scan_wrap;

    always_comb begin
        idx_next = digit_idx;
        if (scan_wrap && lit) begin
            idx_next = (digit_idx == LAST_IDX) ? '0 : digit_idx + 1'b1;
        end
    end

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst) begin
            scan_cnt  <= '0;
            digit_idx <= '0;
            lit       <= 1'b0;
            o_anode   <= panel_pkg::ANODE_OFF;
            o_cathode <= panel_pkg::SEG_BLANK;
        end else begin
            scan_cnt  <= scan_cnt + 1'b1;
            digit_idx <= idx_next;
            lit       <= lit_next;
            if (lit_next) begin
                o_anode   <= ~(panel_pkg::anode_t'(1) << idx_next);
                o_cathode <= i_segs[idx_next];  // follows the decoder every cycle
            end
        end
    end

    a_one_digit_lit: assert property (
        @(posedge clk_dram_ctrl) disable iff (rst)
        $onehot0(~o_anode)
    );

    // anodes only move on a scan tick
    a_anode_on_wrap: assert property (
        @(posedge clk_dram_ctrl) disable iff (rst)
        !$stable(o_anode) |-> $past(scan_wrap)
    );

endmodule

`default_nettype wire

// ==== display/seg_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

// hex nibble to cathode pattern, one per digit
module seg_decoder (
    input  logic            clk_dram_ctrl,
    input  logic            rst,
    input  logic [3:0]      i_nibble,
    output panel_pkg::seg_t o_seg
);

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst) begin
            o_seg <= panel_pkg::SEG_BLANK;
        end else begin
            o_seg <= panel_pkg::SEG_HEX[i_nibble];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/knob_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

// brings the panel controls over from the scanner clock
module knob_sync (
    input  logic                       clk_dram_ctrl,
    input  logic                       rst,
    input  panel_pkg::panel_settings_t i_settings,
    output panel_pkg::panel_settings_t o_settings
);

    panel_pkg::panel_settings_t meta_q;  // first flop, may go metastable
    panel_pkg::panel_settings_t sync_q;

    // knobs move slowly, a level capture is enough here
    always_ff @(posedge clk_dram_ctrl) begin
        if (rst) begin
            meta_q <= '0;
            sync_q <= '0;
        end else begin
            meta_q <= i_settings;
            sync_q <= meta_q;
        end
    end

    assign o_settings = sync_q;

endmodule

`default_nettype wire

// ==== hdl/panel_monitor_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// status display for the dram controller clock domain
module panel_monitor_top #(
    parameter int SCAN_DIV_BITS = 16  // log2 of cycles per digit
) (
    input  logic                       clk_dram_ctrl,
    input  logic                       rst,
    input  panel_pkg::panel_settings_t i_settings,
    input  panel_pkg::page_t           i_page,
    input  logic                       i_req_complete,
    output panel_pkg::seg_t            o_cathode,
    output panel_pkg::anode_t          o_anode
);

    panel_pkg::panel_settings_t settings_sync;
    panel_pkg::disp_word_u      disp_word;
    panel_pkg::seg_t            digit_segs [panel_pkg::NUM_DIGITS];

    knob_sync u_knob_sync (
        .clk_dram_ctrl (clk_dram_ctrl),
        .rst           (rst),
        .i_settings    (i_settings),
        .o_settings    (settings_sync)
    );

    status_page_select u_page_select (
        .clk_dram_ctrl  (clk_dram_ctrl),
        .rst            (rst),
        .i_settings     (settings_sync),
        .i_page         (i_page),
        .i_req_complete (i_req_complete),
        .o_disp_word    (disp_word)
    );

    // one decoder per digit, digit 0 on the low nibble
    for (genvar k = 0; k < panel_pkg::NUM_DIGITS; k++) begin : g_dec
        seg_decoder u_seg_decoder (
            .clk_dram_ctrl (clk_dram_ctrl),
            .rst           (rst),
            .i_nibble      (disp_word.nibbles[k]),
            .o_seg         (digit_segs[k])
        );
    end

    digit_scan #(
        .SCAN_DIV_BITS (SCAN_DIV_BITS)
    ) u_digit_scan (
        .clk_dram_ctrl (clk_dram_ctrl),
        .rst           (rst),
        .i_segs        (digit_segs),
        .o_cathode     (o_cathode),
        .o_anode       (o_anode)
    );

endmodule

`default_nettype wire

// ==== hdl/status_page_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module status_page_select (
    input  logic                       clk_dram_ctrl,
    input  logic                       rst,
    input  panel_pkg::panel_settings_t i_settings,
    input  panel_pkg::page_t           i_page,
    input  logic                       i_req_complete,
    output panel_pkg::disp_word_u      o_disp_word
);

    logic [23:0] req_count;  // completed memory requests, wraps

    function automatic panel_pkg::knob_pair_t knob_pair(
        input panel_pkg::knob_t hi,
        input panel_pkg::knob_t lo
    );
        panel_pkg::knob_pair_t p;
        p.pad_hi  = '0;
        p.knob_hi = hi;
        p.pad_lo  = '0;
        p.knob_lo = lo;
        return p;
    endfunction

    function automatic panel_pkg::route_set_t route_set(
        input panel_pkg::panel_settings_t s
    );
        panel_pkg::route_set_t r;
        r.pad         = '0;
        r.delay       = {1'b0, s.delay_src};
        r.reverb      = {1'b0, s.reverb_src};
        r.filter      = {1'b0, s.filter_src};
        r.distortion  = {1'b0, s.distortion_src};
        r.crush       = {1'b0, s.crush_src};
        r.output_jack = {1'b0, s.output_src};
        return r;
    endfunction

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst) begin
            req_count <= '0;
        end else if (i_req_complete) begin
            req_count <= req_count + 24'd1;
        end
    end

    always_comb begin
        o_disp_word = '0;
        unique case (i_page)
            panel_pkg::PAGE_REQ_COUNT:
                o_disp_word.nibbles = {16'h0000, req_count[15:0]};  // low half only
            panel_pkg::PAGE_VOL_PITCH:
                o_disp_word.knobs = knob_pair(i_settings.volume, i_settings.pitch);
            panel_pkg::PAGE_DLY_WET_RATE:
                o_disp_word.knobs = knob_pair(i_settings.delay_wet, i_settings.delay_rate);
            panel_pkg::PAGE_DLY_FB_REV_WET:
                o_disp_word.knobs = knob_pair(i_settings.delay_feedback, i_settings.reverb_wet);
            panel_pkg::PAGE_REV_SIZE_FB:
                o_disp_word.knobs = knob_pair(i_settings.reverb_size, i_settings.reverb_feedback);
            panel_pkg::PAGE_FILTER:
                o_disp_word.knobs = knob_pair(i_settings.filter_quality, i_settings.filter_cutoff);
            panel_pkg::PAGE_DRIVE_CRUSH:
                o_disp_word.knobs = knob_pair(i_settings.distortion_drive,
                                              i_settings.crush_pressure);
            panel_pkg::PAGE_ROUTES:
                o_disp_word.routes = route_set(i_settings);
        endcase
    end

    // one step per pulse, and no drift between pulses
    a_req_count_step: assert property (
        @(posedge clk_dram_ctrl) disable iff (rst)
        i_req_complete |=> req_count == $past(req_count) + 24'd1
    );
    a_req_count_hold: assert property (
        @(posedge clk_dram_ctrl) disable iff (rst)
        !i_req_complete |=> $stable(req_count)
    );

endmodule

`default_nettype wire

// ==== verif/tb_panel_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_panel_monitor;

    localparam int SCAN_DIV_BITS     = 3;
    localparam int NUM_ENTRIES       = 16;
    localparam int CYCLES_PER_DIGIT  = 1 << SCAN_DIV_BITS;
    localparam int ROUND_CYCLES      = panel_pkg::NUM_DIGITS * CYCLES_PER_DIGIT;
    localparam int WATCHDOG_NS       = NUM_ENTRIES * (2 * ROUND_CYCLES + 10) * 40 * 2;
    localparam int FIRST_LIGHT_LIMIT = 2 * CYCLES_PER_DIGIT;
    localparam int CHANGE_LIMIT      = 2 * CYCLES_PER_DIGIT + 4;

    localparam logic [31:0] LFSR_SEED = 32'h5c3fa246;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;  // x^32 + x^22 + x^2 + x + 1

    localparam panel_pkg::anode_t ALL_DARK = 8'hff;
    localparam panel_pkg::seg_t   SEG_DARK = 7'h7f;

    // one row of the stimulus table
    typedef struct packed {
        panel_pkg::page_t           page;
        panel_pkg::panel_settings_t settings;
        logic [31:0]                pulses;
        logic [31:0]                exp_word;  // display word after this row's pulses
    } stim_entry_t;

    logic                       clk_dram_ctrl;
    logic                       rst;
    panel_pkg::panel_settings_t i_settings;
    panel_pkg::page_t           i_page;
    logic                       i_req_complete;
    panel_pkg::seg_t            o_cathode;
    panel_pkg::anode_t          o_anode;

    stim_entry_t       stim_table [NUM_ENTRIES];
    logic [31:0]       lfsr_state;
    int                value_errors;
    int                event_errors;
    panel_pkg::anode_t prev_anode;
    int                anode_changes;  // since reset, first light counts as one
    logic              anode_moved;

    panel_monitor_top #(
        .SCAN_DIV_BITS (SCAN_DIV_BITS)
    ) UUT (
        .clk_dram_ctrl  (clk_dram_ctrl),
        .rst            (rst),
        .i_settings     (i_settings),
        .i_page         (i_page),
        .i_req_complete (i_req_complete),
        .o_cathode      (o_cathode),
        .o_anode        (o_anode)
    );

    always #20 clk_dram_ctrl = ~clk_dram_ctrl;

    function automatic logic next_lfsr_bit();
        logic out_bit;
        out_bit    = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ LFSR_TAPS;
        end
        return out_bit;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            r = {r[30:0], next_lfsr_bit()};
        end
        return r;
    endfunction

    function automatic panel_pkg::panel_settings_t random_settings();
        panel_pkg::panel_settings_t s;
        s.volume           = panel_pkg::knob_t'(random_bits(10));
        s.pitch            = panel_pkg::knob_t'(random_bits(10));
        s.delay_wet        = panel_pkg::knob_t'(random_bits(10));
        s.delay_rate       = panel_pkg::knob_t'(random_bits(10));
        s.delay_feedback   = panel_pkg::knob_t'(random_bits(10));
        s.reverb_wet       = panel_pkg::knob_t'(random_bits(10));
        s.reverb_size      = panel_pkg::knob_t'(random_bits(10));
        s.reverb_feedback  = panel_pkg::knob_t'(random_bits(10));
        s.filter_quality   = panel_pkg::knob_t'(random_bits(10));
        s.filter_cutoff    = panel_pkg::knob_t'(random_bits(10));
        s.distortion_drive = panel_pkg::knob_t'(random_bits(10));
        s.crush_pressure   = panel_pkg::knob_t'(random_bits(10));
        s.output_src       = panel_pkg::route_t'(random_bits(3));
        s.crush_src        = panel_pkg::route_t'(random_bits(3));
        s.distortion_src   = panel_pkg::route_t'(random_bits(3));
        s.filter_src       = panel_pkg::route_t'(random_bits(3));
        s.reverb_src       = panel_pkg::route_t'(random_bits(3));
        s.delay_src        = panel_pkg::route_t'(random_bits(3));
        return s;
    endfunction

    // display word laid out bit by bit, high knob in the upper half
    function automatic logic [31:0] expected_word(
        input panel_pkg::page_t           p,
        input panel_pkg::panel_settings_t s,
        input logic [31:0]                total
    );
        logic [31:0] w;
        w = '0;
        case (p)
            panel_pkg::PAGE_REQ_COUNT:      w = {16'h0000, total[15:0]};
            panel_pkg::PAGE_VOL_PITCH:      w = {6'd0, s.volume, 6'd0, s.pitch};
            panel_pkg::PAGE_DLY_WET_RATE:   w = {6'd0, s.delay_wet, 6'd0, s.delay_rate};
            panel_pkg::PAGE_DLY_FB_REV_WET: w = {6'd0, s.delay_feedback, 6'd0, s.reverb_wet};
            panel_pkg::PAGE_REV_SIZE_FB:    w = {6'd0, s.reverb_size, 6'd0, s.reverb_feedback};
            panel_pkg::PAGE_FILTER:         w = {6'd0, s.filter_quality, 6'd0, s.filter_cutoff};
            panel_pkg::PAGE_DRIVE_CRUSH:
                w = {6'd0, s.distortion_drive, 6'd0, s.crush_pressure};
            panel_pkg::PAGE_ROUTES:
                w = {8'h00, 1'b0, s.delay_src, 1'b0, s.reverb_src, 1'b0, s.filter_src,
                     1'b0, s.distortion_src, 1'b0, s.crush_src, 1'b0, s.output_src};
        endcase
        return w;
    endfunction

    task automatic build_table();
        logic [31:0] running_total;  // pulses fired so far, row included
        int          e;
        running_total = '0;
        for (e = 0; e < NUM_ENTRIES; e++) begin
            stim_table[e].page     = panel_pkg::page_t'(e[2:0]);  // every page twice
            stim_table[e].settings = random_settings();
            stim_table[e].pulses   = random_bits(4);
            running_total          = running_total + stim_table[e].pulses;
            stim_table[e].exp_word = expected_word(stim_table[e].page,
                                                   stim_table[e].settings, running_total);
        end
    endtask

    task automatic check_cathode(
        input panel_pkg::seg_t expected,
        input panel_pkg::seg_t actual,
        input string           where
    );
        if (actual !== expected) begin
            value_errors++;
            $display("[FAIL] %0t o_cathode (%s) expected %h got %h",
                     $time, where, expected, actual);
        end
    endtask

    task automatic check_anode(
        input panel_pkg::anode_t expected,
        input panel_pkg::anode_t actual,
        input string             where
    );
        if (actual !== expected) begin
            value_errors++;
            $display("[FAIL] %0t o_anode (%s) expected %b got %b",
                     $time, where, expected, actual);
        end
    endtask

    // one clock, outputs looked at on the falling edge
    task automatic step_cycle();
        @(negedge clk_dram_ctrl);
        anode_moved = 1'b0;
        if (o_anode !== prev_anode) begin
            prev_anode = o_anode;
            anode_changes++;
            anode_moved = 1'b1;
        end
    endtask

    task automatic wait_anode_change(output bit ok);
        int cycles;
        cycles = 0;
        ok     = 1'b0;
        while (!ok && cycles < CHANGE_LIMIT) begin
            step_cycle();
            cycles++;
            ok = anode_moved;
        end
        if (!ok) begin
            event_errors++;
            $display("o_anode stayed the same for %0d cycles at %0t", CHANGE_LIMIT, $time);
        end
    endtask

    task automatic check_reset_state();
        int cycles;
        cycles      = 0;
        anode_moved = 1'b0;
        while (!anode_moved && cycles < FIRST_LIGHT_LIMIT) begin
            check_anode(ALL_DARK, o_anode, "before first scan tick");
            check_cathode(SEG_DARK, o_cathode, "before first scan tick");
            step_cycle();
            cycles++;
        end
        if (!anode_moved) begin
            event_errors++;
            $display("no digit lit within %0d cycles after reset", FIRST_LIGHT_LIMIT);
        end else begin
            // all inputs zero on page 0, so digit 0 shows a zero
            check_anode(8'hfe, o_anode, "first scan tick");
            check_cathode(panel_pkg::SEG_HEX[0], o_cathode, "first scan tick");
        end
    endtask

    task automatic apply_entry(input int e);
        stim_entry_t       ent;
        panel_pkg::anode_t exp_anode;
        logic [3:0]        nib;
        bit                ok;
        int                start;
        int unsigned       p;
        int                d;
        ent        = stim_table[e];
        i_page     = ent.page;
        i_settings = ent.settings;
        for (p = 0; p < ent.pulses; p++) begin
            i_req_complete = 1'b1;
            step_cycle();
            i_req_complete = 1'b0;
            step_cycle();  // idle between pulses
        end
        // one full round to settle, then line up so the next digit is 0
        ok    = 1'b1;
        start = anode_changes;
        while (ok && (anode_changes - start < panel_pkg::NUM_DIGITS ||
                      anode_changes % panel_pkg::NUM_DIGITS != 0)) begin
            wait_anode_change(ok);
        end
        for (d = 0; d < panel_pkg::NUM_DIGITS && ok; d++) begin
            wait_anode_change(ok);
            if (ok) begin
                exp_anode    = ALL_DARK;
                exp_anode[d] = 1'b0;  // only digit d pulled low
                nib          = ent.exp_word[4*d +: 4];
                check_anode(exp_anode, o_anode, $sformatf("entry %0d digit %0d", e, d));
                check_cathode(panel_pkg::SEG_HEX[nib], o_cathode,
                              $sformatf("entry %0d digit %0d", e, d));
            end
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("run stopped by the watchdog after %0d ns without finishing", WATCHDOG_NS);
        $display("Test failures found");
        $finish;
    end

    initial begin
        int e;
        $timeformat(-9, 0, " ns", 0);
        clk_dram_ctrl  = 1'b0;
        rst            = 1'b1;
        i_settings     = '0;
        i_page         = panel_pkg::PAGE_REQ_COUNT;
        i_req_complete = 1'b0;
        value_errors   = 0;
        event_errors   = 0;
        prev_anode     = ALL_DARK;
        anode_changes  = 0;
        anode_moved    = 1'b0;
        lfsr_state     = LFSR_SEED;
        build_table();

        repeat (5) @(negedge clk_dram_ctrl);
        rst = 1'b0;
        check_reset_state();

        for (e = 0; e < NUM_ENTRIES; e++) begin
            apply_entry(e);
        end

        $display("errors: %0d wrong values, %0d other failures", value_errors, event_errors);
        if (value_errors == 0 && event_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
